//--- hw/mvd_settings.svh
// Widths and tree constants shared by the MVD pipeline.
// Include wherever a width is needed; the guard makes repeated includes safe.

`ifndef MVD_SETTINGS_SVH
`define MVD_SETTINGS_SVH

// one signed MV component
`define MVD_MV_COMP_W   10

// one signed difference component, one bit wider than an MV component
`define MVD_DIFF_COMP_W 11

// 8x8 block address inside the 64x64 tree block
`define MVD_BLK_ADDR_W  6

// split flags, 1 at 64x64, 4 at 32x32, 16 at 16x16
`define MVD_SPLIT_FLAGS 21

`define MVD_COST_W      6

`endif

//--- hw/mvd_pkg.sv
// Types shared by the MVD pipeline stages and their interfaces.
// Referenced by scoped names, widths come from the settings header.

`include "mvd_settings.svh"

package mvd_pkg;

    // x in the low half, y in the high half
    typedef logic [2*`MVD_MV_COMP_W-1:0]   mv_t;

    typedef logic [2*`MVD_DIFF_COMP_W-1:0] mvd_t;   // same layout as mv_t

    typedef logic [`MVD_BLK_ADDR_W-1:0]    blk_addr_t;   // row * 8 + column

    // 0 is 64x64, 1 is 32x32, 2 is 16x16, 3 is 8x8
    typedef logic [1:0]                    cu_size_t;

    typedef logic [`MVD_COST_W-1:0]        cost_t;   // estimated bits

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_DESCEND,
        WALK_EMIT,
        WALK_DONE
    } walk_state_t;

endpackage

//--- hw/mvd_if.sv
// Valid/ready links between the MVD pipeline stages.
// cu_if carries coding units from the walker, cand_if candidate records.
`timescale 1ns/1ns

interface cu_if;
    logic                valid;
    logic                ready;
    mvd_pkg::blk_addr_t  blk_addr;   // top-left 8x8 block
    mvd_pkg::cu_size_t   size;
    logic                last;       // final unit of the tree

    modport source (output valid, blk_addr, size, last, input ready);
    modport sink   (input valid, blk_addr, size, last, output ready);
endinterface

interface cand_if;
    logic                valid;
    logic                ready;
    mvd_pkg::blk_addr_t  blk_addr;
    mvd_pkg::mv_t        mv_c;       // own vector
    mvd_pkg::mv_t        mv_a;       // left neighbour
    logic                a_avail;
    mvd_pkg::mv_t        mv_b;       // above neighbour
    logic                b_avail;
    logic                last;

    modport source (
        output valid, blk_addr, mv_c, mv_a, a_avail, mv_b, b_avail, last,
        input  ready
    );
    modport sink (
        input  valid, blk_addr, mv_c, mv_a, a_avail, mv_b, b_avail, last,
        output ready
    );
endinterface

//--- hw/cu_tree_walker.sv
// Decode stage, turns the 21 split flags into a z-order stream of coding units.
// A start pulse latches the flags, then one unit per cycle leaves on cu,
// the final one flagged as last.
`timescale 1ns/1ns
`include "mvd_settings.svh"

module cu_tree_walker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    input  logic [`MVD_SPLIT_FLAGS-1:0] split_flags_i,
    output logic                        busy_o,
    cu_if.source                        cu
);

    mvd_pkg::walk_state_t        state_r;
    logic [`MVD_SPLIT_FLAGS-1:0] flags_r;      // latched tree shape
    logic [`MVD_BLK_ADDR_W-1:0]  idx_r;        // z-order index of unit on cu
    mvd_pkg::cu_size_t           size_r;
    logic                        last_r;
    logic [`MVD_BLK_ADDR_W-1:0]  walk_idx;     // unit being resolved
    mvd_pkg::cu_size_t           walk_size;
    logic [`MVD_BLK_ADDR_W:0]    walk_end;     // one past it, carry means last

    // 8x8 blocks covered by a unit, 64 >> (2 * size)
    function automatic logic [`MVD_BLK_ADDR_W:0] blk_count(input mvd_pkg::cu_size_t size);
        return {1'b1, {`MVD_BLK_ADDR_W{1'b0}}} >> {size, 1'b0};
    endfunction

    // descend from the root while the node covering idx is split
    function automatic mvd_pkg::cu_size_t resolve(
        input logic [`MVD_BLK_ADDR_W-1:0]  idx,
        input logic [`MVD_SPLIT_FLAGS-1:0] flags
    );
        mvd_pkg::cu_size_t size;
        size = 2'd3;
        if (!flags[0])
            size = 2'd0;
        else if (!flags[5'd1 + 5'(idx[5:4])])    // 32x32 quadrant
            size = 2'd1;
        else if (!flags[5'd5 + 5'(idx[5:2])])    // 16x16 node
            size = 2'd2;
        return size;
    endfunction

    always_comb begin
        if (state_r == mvd_pkg::WALK_EMIT)
            walk_idx = idx_r + `MVD_BLK_ADDR_W'(blk_count(size_r));
        else
            walk_idx = '0;
        walk_size = resolve(walk_idx, flags_r);
        walk_end  = {1'b0, walk_idx} + blk_count(walk_size);
    end

    always_ff @(posedge clk) begin
        if (state_r == mvd_pkg::WALK_IDLE && start_i)
            flags_r <= split_flags_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_r <= mvd_pkg::WALK_IDLE;
            idx_r   <= '0;
            size_r  <= '0;
            last_r  <= 1'b0;
        end else begin
            case (state_r)
                mvd_pkg::WALK_IDLE: begin
                    if (start_i)
                        state_r <= mvd_pkg::WALK_DESCEND;
                end
                mvd_pkg::WALK_DESCEND: begin    // resolve the first unit
                    idx_r   <= walk_idx;
                    size_r  <= walk_size;
                    last_r  <= walk_end[`MVD_BLK_ADDR_W];
                    state_r <= mvd_pkg::WALK_EMIT;
                end
                mvd_pkg::WALK_EMIT: begin
                    if (cu.valid && cu.ready) begin
                        if (last_r) begin
                            state_r <= mvd_pkg::WALK_DONE;
                        end else begin
                            idx_r  <= walk_idx;
                            size_r <= walk_size;
                            last_r <= walk_end[`MVD_BLK_ADDR_W];
                        end
                    end
                end
                default: state_r <= mvd_pkg::WALK_IDLE;
            endcase
        end
    end

    assign busy_o   = (state_r != mvd_pkg::WALK_IDLE);
    assign cu.valid = (state_r == mvd_pkg::WALK_EMIT);
    assign cu.size  = size_r;
    assign cu.last  = last_r;

    // de-interleave the z-order index into row and column
    assign cu.blk_addr = {idx_r[5], idx_r[3], idx_r[1], idx_r[4], idx_r[2], idx_r[0]};

    // a new tree may only start once the previous walk has finished
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy_o |-> !start_i)
        else $error("start_i raised while the walker is busy");

endmodule

//--- hw/mv_candidate_fetch.sv
// Execute stage, reads the own, left and above vectors of each coding unit
// from the MV buffer and presents them as one candidate record.
// Reads go out on three consecutive cycles, data returns one cycle later.
`timescale 1ns/1ns

module mv_candidate_fetch (
    input  logic               clk,
    input  logic               rst_n,
    cu_if.sink                 cu,
    output logic               mv_rd_en_o,
    output mvd_pkg::blk_addr_t mv_rd_addr_o,
    input  mvd_pkg::mv_t       mv_rd_data_i,
    cand_if.source             cand
);

    logic [2:0]         phase_r;    // 0 idle, 1..3 read C A B, 4 capture B
    mvd_pkg::blk_addr_t addr_r;
    mvd_pkg::cu_size_t  size_r;
    logic               last_r;
    logic               valid_r;
    mvd_pkg::mv_t       mv_c_r;
    mvd_pkg::mv_t       mv_a_r;
    mvd_pkg::mv_t       mv_b_r;
    logic [3:0]         pos_x;      // in 8x8 units
    logic [3:0]         pos_y;
    logic [3:0]         width;
    logic [3:0]         a_col;
    logic [3:0]         a_row;
    logic [3:0]         b_col;
    logic [3:0]         b_row;
    mvd_pkg::blk_addr_t addr_a;
    mvd_pkg::blk_addr_t addr_b;

    // neighbour positions
    always_comb begin
        pos_x  = {1'b0, addr_r[2:0]};
        pos_y  = {1'b0, addr_r[5:3]};
        width  = 4'd8 >> size_r;
        a_col  = pos_x - 4'd1;              // left of the bottom-left block
        a_row  = pos_y + width - 4'd1;
        b_col  = pos_x + width - 4'd1;      // above the top-right block
        b_row  = pos_y - 4'd1;
        addr_a = {a_row[2:0], a_col[2:0]};
        addr_b = {b_row[2:0], b_col[2:0]};
    end

    // new unit only once the previous record is gone or leaving now
    assign cu.ready = (phase_r == 3'd0) && (!valid_r || cand.ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_r <= 3'd0;
            valid_r <= 1'b0;
        end else begin
            if (cu.valid && cu.ready)
                phase_r <= 3'd1;
            else if (phase_r == 3'd4)
                phase_r <= 3'd0;
            else if (phase_r != 3'd0)
                phase_r <= phase_r + 3'd1;

            if (phase_r == 3'd4)
                valid_r <= 1'b1;
            else if (cand.ready)
                valid_r <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cu.valid && cu.ready) begin
            addr_r <= cu.blk_addr;
            size_r <= cu.size;
            last_r <= cu.last;
        end
        case (phase_r)
            3'd2:    mv_c_r <= mv_rd_data_i;
            3'd3:    mv_a_r <= mv_rd_data_i;
            3'd4:    mv_b_r <= mv_rd_data_i;
            default: ;
        endcase
    end

    assign mv_rd_en_o = (phase_r >= 3'd1) && (phase_r <= 3'd3);

    always_comb begin
        case (phase_r)
            3'd1:    mv_rd_addr_o = addr_r;    // own vector
            3'd2:    mv_rd_addr_o = addr_a;
            default: mv_rd_addr_o = addr_b;
        endcase
    end

    assign cand.valid    = valid_r;
    assign cand.blk_addr = addr_r;
    assign cand.mv_c     = mv_c_r;
    assign cand.mv_a     = mv_a_r;
    assign cand.a_avail  = (addr_r[2:0] != 3'd0);    // not on the left edge
    assign cand.mv_b     = mv_b_r;
    assign cand.b_avail  = (addr_r[5:3] != 3'd0);    // not on the top row
    assign cand.last     = last_r;

    // the buffer port stays quiet while a record waits downstream
    a_no_read_pending: assert property (@(posedge clk) disable iff (!rst_n)
        cand.valid |-> !mv_rd_en_o)
        else $error("MV read issued while the candidate record is pending");

endmodule

//--- hw/mvd_select.sv
// Result stage, forms both predictors, computes the differences and their
// estimated bit cost and registers the cheaper one with its index.
// done_o pulses the cycle after the last unit of a tree has left.
`timescale 1ns/1ns
`include "mvd_settings.svh"

module mvd_select (
    input  logic               clk,
    input  logic               rst_n,
    cand_if.sink               cand,
    output logic               mvd_valid_o,
    input  logic               mvd_ready_i,
    output mvd_pkg::blk_addr_t mvd_addr_o,
    output mvd_pkg::mvd_t      mvd_o,
    output logic               mvp_idx_o,
    output logic               done_o
);

    localparam int MW = `MVD_MV_COMP_W;
    localparam int DW = `MVD_DIFF_COMP_W;

    mvd_pkg::mv_t   pred0;
    mvd_pkg::mv_t   pred1;
    mvd_pkg::mvd_t  diff0;
    mvd_pkg::mvd_t  diff1;
    mvd_pkg::cost_t cost0;
    mvd_pkg::cost_t cost1;
    logic           pick1;
    logic           last_r;

    // C minus P per component, sign extended
    function automatic mvd_pkg::mvd_t pair_diff(input mvd_pkg::mv_t c, input mvd_pkg::mv_t p);
        logic [DW-1:0] dx;
        logic [DW-1:0] dy;
        dx = {c[MW-1], c[MW-1:0]} - {p[MW-1], p[MW-1:0]};
        dy = {c[2*MW-1], c[2*MW-1:MW]} - {p[2*MW-1], p[2*MW-1:MW]};
        return {dy, dx};
    endfunction

    // 1 for zero, else 2 * msb position of the magnitude + 3
    function automatic mvd_pkg::cost_t comp_cost(input logic [DW-1:0] d);
        logic [DW-1:0]  mag;
        mvd_pkg::cost_t cost;
        mag  = d[DW-1] ? (~d + 1'b1) : d;
        cost = mvd_pkg::cost_t'(1);
        for (int i = 0; i < DW; i++) begin
            if (mag[i])
                cost = mvd_pkg::cost_t'(2 * i + 3);
        end
        return cost;
    endfunction

    function automatic mvd_pkg::cost_t pair_cost(input mvd_pkg::mvd_t d);
        return comp_cost(d[DW-1:0]) + comp_cost(d[2*DW-1:DW]);
    endfunction

    always_comb begin
        if (cand.a_avail)
            pred0 = cand.mv_a;
        else if (cand.b_avail)
            pred0 = cand.mv_b;
        else
            pred0 = '0;
        // B equal to A is pruned, slot 1 then falls back to zero
        if (cand.a_avail && cand.b_avail && (cand.mv_b != cand.mv_a))
            pred1 = cand.mv_b;
        else
            pred1 = '0;
        diff0 = pair_diff(cand.mv_c, pred0);
        diff1 = pair_diff(cand.mv_c, pred1);
        cost0 = pair_cost(diff0);
        cost1 = pair_cost(diff1);
        pick1 = (cost1 < cost0);    // ties stay on index 0
    end

    assign cand.ready = !mvd_valid_o || mvd_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mvd_valid_o <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            done_o <= mvd_valid_o && mvd_ready_i && last_r;
            if (cand.valid && cand.ready)
                mvd_valid_o <= 1'b1;
            else if (mvd_ready_i)
                mvd_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cand.valid && cand.ready) begin
            mvd_addr_o <= cand.blk_addr;
            mvd_o      <= pick1 ? diff1 : diff0;
            mvp_idx_o  <= pick1;
            last_r     <= cand.last;
        end
    end

    // a stalled result keeps its payload until it is taken
    a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (mvd_valid_o && !mvd_ready_i) |=>
            (mvd_valid_o && $stable({mvd_addr_o, mvd_o, mvp_idx_o})))
        else $error("MVD output changed while stalled");

endmodule

//--- hw/mvd_top.sv
// Motion-vector-difference unit for one 64x64 tree block.
// Walker, candidate fetch and select stages joined by valid/ready links,
// plain ports to the MV buffer and the result consumer.
`timescale 1ns/1ns
`include "mvd_settings.svh"

module mvd_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    input  logic [`MVD_SPLIT_FLAGS-1:0] split_flags_i,
    output logic                        busy_o,
    output logic                        mv_rd_en_o,
    output mvd_pkg::blk_addr_t          mv_rd_addr_o,
    input  mvd_pkg::mv_t                mv_rd_data_i,
    output logic                        mvd_valid_o,
    input  logic                        mvd_ready_i,
    output mvd_pkg::blk_addr_t          mvd_addr_o,
    output mvd_pkg::mvd_t               mvd_o,
    output logic                        mvp_idx_o,
    output logic                        done_o
);

    cu_if   cu_bus ();      // walker to fetch
    cand_if cand_bus ();    // fetch to select

    cu_tree_walker cu_tree_walker_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .split_flags_i (split_flags_i),
        .busy_o        (busy_o),
        .cu            (cu_bus.source)
    );

    mv_candidate_fetch mv_candidate_fetch_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cu            (cu_bus.sink),
        .mv_rd_en_o    (mv_rd_en_o),
        .mv_rd_addr_o  (mv_rd_addr_o),
        .mv_rd_data_i  (mv_rd_data_i),
        .cand          (cand_bus.source)
    );

    mvd_select mvd_select_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cand          (cand_bus.sink),
        .mvd_valid_o   (mvd_valid_o),
        .mvd_ready_i   (mvd_ready_i),
        .mvd_addr_o    (mvd_addr_o),
        .mvd_o         (mvd_o),
        .mvp_idx_o     (mvp_idx_o),
        .done_o        (done_o)
    );

endmodule

//--- verif/mvd_ref_model.svh
// Reference model for the MVD testbench, included inside the testbench module.
// Rebuilds the expected z-order outputs from the split flags and mv_table.

// xorshift32 step, source of all random stimulus
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
endfunction

// signed component of a vector, k 0 is x and 1 is y
function automatic int comp(input mvd_pkg::mv_t mv, input int k);
    logic signed [`MVD_MV_COMP_W-1:0] v;
    v = mv[k*`MVD_MV_COMP_W +: `MVD_MV_COMP_W];
    return int'(v);
endfunction

// 1 for zero, then two more per bit of the magnitude
function automatic int bit_cost(input int d);
    int mag;
    int cost;
    mag  = (d < 0) ? -d : d;
    cost = 1;
    while (mag > 0) begin
        cost = cost + 2;
        mag  = mag >> 1;
    end
    return cost;
endfunction

// expected result of the unit at column x, row y, w blocks wide
task automatic emit_unit(input int x, input int y, input int w);
    mvd_pkg::mv_t c;
    mvd_pkg::mv_t p0;
    mvd_pkg::mv_t p1;
    int           dx0, dy0, dx1, dy1;
    logic         pick1;
    c  = mv_table[y*8 + x];
    p0 = '0;
    p1 = '0;
    if (x > 0)
        p0 = mv_table[(y + w - 1)*8 + x - 1];    // left of bottom-left block
    else if (y > 0)
        p0 = mv_table[(y - 1)*8 + x + w - 1];    // above top-right block
    if (x > 0 && y > 0 && mv_table[(y - 1)*8 + x + w - 1] != p0)
        p1 = mv_table[(y - 1)*8 + x + w - 1];
    dx0   = comp(c, 0) - comp(p0, 0);
    dy0   = comp(c, 1) - comp(p0, 1);
    dx1   = comp(c, 0) - comp(p1, 0);
    dy1   = comp(c, 1) - comp(p1, 1);
    pick1 = (bit_cost(dx1) + bit_cost(dy1)) < (bit_cost(dx0) + bit_cost(dy0));
    exp_addr.push_back(mvd_pkg::blk_addr_t'(y*8 + x));
    exp_idx.push_back(pick1);
    if (pick1)
        exp_mvd.push_back({dy1[`MVD_DIFF_COMP_W-1:0], dx1[`MVD_DIFF_COMP_W-1:0]});
    else
        exp_mvd.push_back({dy0[`MVD_DIFF_COMP_W-1:0], dx0[`MVD_DIFF_COMP_W-1:0]});
endtask

// quadrants in z-order: top-left, top-right, bottom-left, bottom-right
task automatic build_expected(input logic [`MVD_SPLIT_FLAGS-1:0] flags);
    int qx, qy, sx, sy;
    exp_addr.delete();
    exp_mvd.delete();
    exp_idx.delete();
    if (!flags[0]) begin
        emit_unit(0, 0, 8);
        return;
    end
    for (int q = 0; q < 4; q++) begin
        qx = (q % 2) * 4;
        qy = (q / 2) * 4;
        if (!flags[1 + q]) begin
            emit_unit(qx, qy, 4);
        end else begin
            for (int s = 0; s < 4; s++) begin
                sx = qx + (s % 2) * 2;
                sy = qy + (s / 2) * 2;
                if (!flags[5 + q*4 + s])
                    emit_unit(sx, sy, 2);
                else
                    for (int t = 0; t < 4; t++)
                        emit_unit(sx + t % 2, sy + t / 2, 1);
            end
        end
    end
endtask

//--- verif/mvd_tb.sv
// Testbench for the MVD unit. Random trees and vectors from a fixed seed,
// every output transfer compared with the included reference model.
`timescale 1ns/1ns
`include "mvd_settings.svh"

module mvd_tb;

    logic                        clk;
    logic                        rst_n;
    logic                        start_i;
    logic [`MVD_SPLIT_FLAGS-1:0] split_flags_i;
    logic                        busy_o;
    logic                        mv_rd_en_o;
    mvd_pkg::blk_addr_t          mv_rd_addr_o;
    mvd_pkg::mv_t                mv_rd_data_i;
    logic                        mvd_valid_o;
    logic                        mvd_ready_i;
    mvd_pkg::blk_addr_t          mvd_addr_o;
    mvd_pkg::mvd_t               mvd_o;
    logic                        mvp_idx_o;
    logic                        done_o;

    mvd_pkg::mv_t       mv_table [64];    // MV buffer contents
    mvd_pkg::blk_addr_t exp_addr [$];
    mvd_pkg::mvd_t      exp_mvd [$];
    logic               exp_idx [$];
    logic [31:0]        rng;
    logic [31:0]        ready_rng;
    logic               random_ready;
    logic               abort;            // set on a timeout
    logic               hold_check;
    logic [28:0]        held;             // address, difference, index
    logic               xfer_prev;
    int                 errors;
    int                 done_count;
    int                 tests_run;
    int                 tests_failed;
    string              test_name;

    `include "mvd_ref_model.svh"

    mvd_top mvd_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // buffer answers one cycle after the enable
    always @(posedge clk) begin
        if (mv_rd_en_o)
            mv_rd_data_i <= mv_table[mv_rd_addr_o];
    end

    always @(posedge clk) begin
        ready_rng = xorshift32(ready_rng);
        mvd_ready_i <= random_ready ? ready_rng[3] : 1'b1;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (hold_check && (!mvd_valid_o || held != {mvd_addr_o, mvd_o, mvp_idx_o})) begin
                errors++;
                $display("%s: output dropped or changed while stalled", test_name);
            end
            if (done_o && !(xfer_prev && exp_addr.size() == 0)) begin
                errors++;
                $display("%s: done_o pulsed without the last transfer before it", test_name);
            end
            if (done_o)
                done_count++;
            hold_check = mvd_valid_o && !mvd_ready_i;
            held       = {mvd_addr_o, mvd_o, mvp_idx_o};
            xfer_prev  = mvd_valid_o && mvd_ready_i;
            if (xfer_prev)
                check_output();
        end
    end

    task automatic check_output();
        if (exp_addr.size() == 0) begin
            errors++;
            $display("%s: output transfer with nothing left to expect", test_name);
            return;
        end
        if (mvd_addr_o != exp_addr[0]) begin
            errors++;
            $display("CHECK FAILED %s address expected %0d actual %0d",
                     test_name, exp_addr[0], mvd_addr_o);
        end
        if (mvd_o != exp_mvd[0]) begin
            errors++;
            $display("CHECK FAILED %s mvd expected %h actual %h", test_name, exp_mvd[0], mvd_o);
        end
        if (mvp_idx_o != exp_idx[0]) begin
            errors++;
            $display("CHECK FAILED %s index expected %0d actual %0d",
                     test_name, exp_idx[0], mvp_idx_o);
        end
        void'(exp_addr.pop_front());
        void'(exp_mvd.pop_front());
        void'(exp_idx.pop_front());
    endtask

    // random vectors, or the first one copied everywhere
    task automatic fill_table(input logic same);
        for (int i = 0; i < 64; i++) begin
            rng = xorshift32(rng);
            mv_table[i] = (same && i > 0) ? mv_table[0] : rng[19:0];
        end
    endtask

    // one random vector per anti-diagonal, so every left and above neighbour match
    task automatic fill_diagonals();
        for (int i = 0; i < 64; i++) begin
            rng = xorshift32(rng);
            mv_table[i] = (i >= 8 && i % 8 != 7) ? mv_table[i - 7] : rng[19:0];
        end
    endtask

    task automatic run_tree(input logic [`MVD_SPLIT_FLAGS-1:0] flags);
        int t;
        if (abort)
            return;
        build_expected(flags);
        done_count = 0;
        @(posedge clk);
        split_flags_i <= flags;
        start_i       <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        @(posedge clk);
        if (!busy_o) begin
            errors++;
            $display("%s: busy_o not high after start", test_name);
        end
        t = 0;
        while (done_count == 0 && t < 4000) begin
            @(posedge clk);
            t++;
        end
        if (done_count == 0) begin
            errors++;
            abort = 1'b1;
            $display("%s: timed out waiting for done_o", test_name);
            return;
        end
        repeat (4) @(posedge clk);    // room for a second pulse
        if (done_count != 1 || exp_addr.size() != 0 || busy_o) begin
            errors++;
            $display("%s: %0d done pulses, %0d outputs missing, busy_o %b afterwards",
                     test_name, done_count, exp_addr.size(), busy_o);
        end
    endtask

    task automatic finish_test(input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - err_before);
        end
    endtask

    initial begin
        int                          err_before;
        logic [`MVD_SPLIT_FLAGS-1:0] flags;
        rst_n         = 1'b0;
        start_i       = 1'b0;
        split_flags_i = '0;
        mv_rd_data_i  = '0;
        mvd_ready_i   = 1'b0;
        random_ready  = 1'b0;
        abort         = 1'b0;
        hold_check    = 1'b0;
        held          = '0;
        xfer_prev     = 1'b0;
        errors        = 0;
        done_count    = 0;
        tests_run     = 0;
        tests_failed  = 0;
        rng           = 32'h41ed;
        ready_rng     = 32'h41ed;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        test_name  = "reset_single_cu";
        err_before = errors;
        if (busy_o || mvd_valid_o || mv_rd_en_o || done_o) begin
            errors++;
            $display("%s: outputs not low after reset", test_name);
        end
        fill_table(1'b0);
        run_tree('0);
        finish_test(err_before);

        test_name  = "full_split";
        err_before = errors;
        fill_table(1'b0);
        run_tree('1);
        finish_test(err_before);

        test_name  = "random_trees";
        err_before = errors;
        for (int n = 0; n < 20; n++) begin
            rng      = xorshift32(rng);
            flags    = rng[`MVD_SPLIT_FLAGS-1:0];
            flags[0] = rng[31] | rng[30];    // mostly split at the root
            fill_table(1'b0);
            run_tree(flags);
        end
        finish_test(err_before);

        test_name    = "random_ready";
        err_before   = errors;
        random_ready <= 1'b1;
        for (int n = 0; n < 10; n++) begin
            rng   = xorshift32(rng);
            flags = (n == 0) ? '1 : rng[`MVD_SPLIT_FLAGS-1:0];
            fill_table(1'b0);
            run_tree(flags);
        end
        random_ready <= 1'b0;
        finish_test(err_before);

        test_name  = "equal_vectors";
        err_before = errors;
        fill_table(1'b1);
        run_tree('1);
        fill_diagonals();    // neighbours equal, own vector differs
        run_tree('1);
        finish_test(err_before);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- build.f
+incdir+hw
+incdir+verif
hw/mvd_pkg.sv
hw/mvd_if.sv
hw/cu_tree_walker.sv
hw/mv_candidate_fetch.sv
hw/mvd_select.sv
hw/mvd_top.sv
verif/mvd_tb.sv

//--- run.sh
#!/bin/sh
# build and run the MVD testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module mvd_tb -f build.f -o mvd_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/mvd_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
